// File: files.f
hw/bpu_pkg.sv
hw/bpu_upd_if.sv
hw/btb_lookup_if.sv
hw/branch_target_buffer.sv
hw/pattern_history_table.sv
hw/next_pc_logic.sv
hw/bpu_top.sv
testbench/bpu_props.sv
testbench/tb_bpu.sv

// File: hw/bpu_pkg.sv
// Shared widths, branch types and counter encoding for the fetch branch predictor
`default_nettype none

package bpu_pkg;

  // ==================================================
  // Address types
  // ==================================================

  // Full byte address
  typedef logic [31:0] addr_t;

  // Word address, pc bits 31 to 2
  typedef logic [29:0] word_addr_t;

  // Bytes per fetch block, two 32-bit slots
  localparam int unsigned FETCH_BYTES = 8;

  // ==================================================
  // Branch classification
  // ==================================================

  // Kind of control transfer stored per BTB entry
  typedef enum logic [1:0] {
    BR_NONE = 2'b00,
    BR_COND = 2'b01,
    BR_JUMP = 2'b10
  } br_type_e;

  // One bit per fetch slot, bit 0 is the lower word
  typedef logic [1:0] slot_mask_t;

  // ==================================================
  // Direction counters
  // ==================================================

  // 2-bit saturating counter, msb set means taken
  typedef logic [1:0] ctr_t;

  // Weakly not-taken
  localparam ctr_t CTR_RESET = 2'b01;

endpackage

`default_nettype wire

// File: hw/bpu_top.sv
// Fetch branch predictor top level joining BTB, PHT and next-PC logic
`default_nettype none

module bpu_top #(
  parameter int unsigned    BTB_IDX_W = 4,
  parameter int unsigned    PHT_IDX_W = 5,
  parameter bpu_pkg::addr_t RESET_PC  = 32'h1c00_0000
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // Backend update
  input  logic                 upd_valid_i,
  input  bpu_pkg::addr_t       upd_pc_i,
  input  bpu_pkg::addr_t       upd_target_i,
  input  bpu_pkg::br_type_e    upd_br_type_i,
  input  logic                 upd_taken_i,
  // Backend redirect
  input  logic                 redirect_i,
  input  bpu_pkg::addr_t       redirect_target_i,
  // Fetch response
  input  logic                 fetch_ready_i,
  output logic                 fetch_valid_o,
  output bpu_pkg::addr_t       fetch_pc_o,
  output bpu_pkg::addr_t       fetch_npc_o,
  output bpu_pkg::slot_mask_t  slot_valid_o,
  output logic                 taken_o,
  output logic                 br_slot_o
);

  // ==================================================
  // Buses
  // ==================================================

  bpu_upd_if     upd_bus ();
  btb_lookup_if  lkp_bus ();

  bpu_pkg::addr_t       rd_pc;
  bpu_pkg::slot_mask_t  pred_taken;

  // Update ports onto the shared bus
  assign upd_bus.valid   = upd_valid_i;
  assign upd_bus.pc      = upd_pc_i;
  assign upd_bus.target  = upd_target_i;
  assign upd_bus.br_type = upd_br_type_i;
  assign upd_bus.taken   = upd_taken_i;

  // ==================================================
  // Blocks
  // ==================================================

  branch_target_buffer #(
    .BTB_IDX_W (BTB_IDX_W)
  ) u_btb (
    .clk   (clk),
    .rst_n (rst_n),
    .upd   (upd_bus.btb_snk),
    .lkp   (lkp_bus.rsp)
  );

  pattern_history_table #(
    .PHT_IDX_W (PHT_IDX_W)
  ) u_pht (
    .clk          (clk),
    .rst_n        (rst_n),
    .upd          (upd_bus.pht_snk),
    .rd_pc_i      (rd_pc),
    .pred_taken_o (pred_taken)
  );

  next_pc_logic #(
    .RESET_PC (RESET_PC)
  ) u_npc (
    .clk               (clk),
    .rst_n             (rst_n),
    .redirect_i        (redirect_i),
    .redirect_target_i (redirect_target_i),
    .fetch_ready_i     (fetch_ready_i),
    .lkp               (lkp_bus.req),
    .pred_taken_i      (pred_taken),
    .rd_pc_o           (rd_pc),
    .fetch_valid_o     (fetch_valid_o),
    .fetch_pc_o        (fetch_pc_o),
    .fetch_npc_o       (fetch_npc_o),
    .slot_valid_o      (slot_valid_o),
    .taken_o           (taken_o),
    .br_slot_o         (br_slot_o)
  );

endmodule

`default_nettype wire

// File: hw/bpu_upd_if.sv
// Backend update bus carrying resolved branch outcomes into the predictor tables
`default_nettype none

interface bpu_upd_if;

  // Update strobe, no backpressure
  logic                 valid;
  // Byte address of the resolved branch
  bpu_pkg::addr_t       pc;
  // Resolved target address
  bpu_pkg::addr_t       target;
  // Branch kind, BR_NONE invalidates the BTB entry
  bpu_pkg::br_type_e    br_type;
  // Resolved direction
  logic                 taken;

  // Driver side, fed from the top-level ports
  modport src (
    output valid, pc, target, br_type
  , output taken
  );

  // BTB needs no direction
  modport btb_snk (
    input valid, pc, target, br_type
  );

  // PHT needs no target
  modport pht_snk (
    input valid, pc, br_type, taken
  );

endinterface

`default_nettype wire

// File: hw/branch_target_buffer.sv
// Direct-mapped two-bank branch target buffer with tag compare and synchronous read
`default_nettype none

module branch_target_buffer #(
  parameter int unsigned BTB_IDX_W = 4
) (
  input  logic          clk,
  input  logic          rst_n,
  bpu_upd_if.btb_snk    upd,
  btb_lookup_if.rsp     lkp
);

  // Entries per bank
  localparam int unsigned DEPTH = 1 << BTB_IDX_W;
  // Tag covers pc bits above the index and the slot bit
  localparam int unsigned TAG_W = 29 - BTB_IDX_W;

  typedef logic [TAG_W-1:0]     tag_t;
  typedef logic [BTB_IDX_W-1:0] idx_t;

  // ==================================================
  // Entry storage
  // ==================================================

  logic                 ent_valid [2][DEPTH];
  tag_t                 ent_tag   [2][DEPTH];
  bpu_pkg::br_type_e    ent_type  [2][DEPTH];
  bpu_pkg::word_addr_t  ent_tgt   [2][DEPTH];

  // Write address split
  logic  wr_bank;
  idx_t  wr_idx;
  tag_t  wr_tag;

  // Read address split, same index for both banks
  idx_t  rd_idx;
  tag_t  rd_tag;

  // pc[2] picks the slot bank
  assign wr_bank = upd.pc[2];
  assign wr_idx  = upd.pc[BTB_IDX_W+2:3];
  assign wr_tag  = upd.pc[31:BTB_IDX_W+3];

  assign rd_idx  = lkp.rd_pc[BTB_IDX_W+2:3];
  assign rd_tag  = lkp.rd_pc[31:BTB_IDX_W+3];

  // Valid bits, every entry empty out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int b = 0; b < 2; b++) begin
        for (int i = 0; i < DEPTH; i++) begin
          ent_valid[b][i] <= 1'b0;
        end
      end
    end else if (upd.valid) begin
      // BR_NONE drops the entry
      ent_valid[wr_bank][wr_idx] <= (upd.br_type != bpu_pkg::BR_NONE);
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (upd.valid) begin
      ent_tag[wr_bank][wr_idx]  <= wr_tag;
      ent_type[wr_bank][wr_idx] <= upd.br_type;
      ent_tgt[wr_bank][wr_idx]  <= upd.target[31:2];
    end
  end

  // ==================================================
  // Synchronous read
  // ==================================================

  logic                 q_valid [2];
  tag_t                 q_tag   [2];
  bpu_pkg::br_type_e    q_type  [2];
  bpu_pkg::word_addr_t  q_tgt   [2];
  // Tag of the looked-up block
  tag_t                 q_req_tag;

  // Old contents win over a same-cycle write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_valid[0] <= 1'b0;
      q_valid[1] <= 1'b0;
    end else begin
      q_valid[0] <= ent_valid[0][rd_idx];
      q_valid[1] <= ent_valid[1][rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    q_req_tag <= rd_tag;
    for (int b = 0; b < 2; b++) begin
      q_tag[b]  <= ent_tag[b][rd_idx];
      q_type[b] <= ent_type[b][rd_idx];
      q_tgt[b]  <= ent_tgt[b][rd_idx];
    end
  end

  // Tag compare after the read register
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      lkp.hit[b]     = q_valid[b] && (q_tag[b] == q_req_tag);
      lkp.br_type[b] = q_type[b];
      lkp.target[b]  = q_tgt[b];
    end
  end

endmodule

`default_nettype wire

// File: hw/btb_lookup_if.sv
// BTB lookup channel between the next-PC logic and the target buffer
`default_nettype none

interface btb_lookup_if;

  // Read address, the PC of the next fetch block
  bpu_pkg::addr_t       rd_pc;

  // Per-slot results, valid one cycle after rd_pc
  // Tag match with a live entry
  bpu_pkg::slot_mask_t  hit;
  // Stored branch kind per slot
  bpu_pkg::br_type_e    br_type [2];
  // Stored target per slot, word granular
  bpu_pkg::word_addr_t  target  [2];

  // Next-PC side issues the address and consumes results
  modport req (
    output rd_pc,
    input  hit,
    input  br_type,
    input  target
  );

  // BTB side
  modport rsp (
    input  rd_pc,
    output hit,
    output br_type,
    output target
  );

endinterface

`default_nettype wire

// File: hw/next_pc_logic.sv
// PC register, fetch handshake and next-PC prediction from BTB and PHT results
`default_nettype none

module next_pc_logic #(
  parameter bpu_pkg::addr_t RESET_PC = 32'h1c00_0000
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // Backend redirect, always accepted
  input  logic                 redirect_i,
  input  bpu_pkg::addr_t       redirect_target_i,
  // Fetch consumer
  input  logic                 fetch_ready_i,
  // Table results for the current pc
  btb_lookup_if.req            lkp,
  input  bpu_pkg::slot_mask_t  pred_taken_i,
  // Table read address
  output bpu_pkg::addr_t       rd_pc_o,
  // Fetch response
  output logic                 fetch_valid_o,
  output bpu_pkg::addr_t       fetch_pc_o,
  output bpu_pkg::addr_t       fetch_npc_o,
  output bpu_pkg::slot_mask_t  slot_valid_o,
  output logic                 taken_o,
  output logic                 br_slot_o
);

  // Clears the offset inside a fetch block
  localparam bpu_pkg::addr_t BLK_MASK = ~bpu_pkg::addr_t'(bpu_pkg::FETCH_BYTES - 1);

  bpu_pkg::addr_t       pc_q;
  bpu_pkg::addr_t       npc;
  bpu_pkg::addr_t       pred_npc;
  bpu_pkg::addr_t       seq_npc;
  logic                 primed_q;
  logic                 fire;
  logic                 slot0_v;
  logic                 slot1_v;
  logic                 tk0;
  logic                 tk1;
  logic                 pred_tk [2];

  // ==================================================
  // Prediction combine
  // ==================================================

  // Per-slot direction from branch type and counter
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      pred_tk[s] = lkp.hit[s] &&
                   ((lkp.br_type[s] == bpu_pkg::BR_JUMP) ||
                    ((lkp.br_type[s] == bpu_pkg::BR_COND) && pred_taken_i[s]));
    end
  end

  // Odd-word pc skips slot 0
  assign slot0_v = ~pc_q[2];
  assign tk0     = slot0_v & pred_tk[0];
  // Taken slot 0 shadows slot 1
  assign slot1_v = ~tk0;
  assign tk1     = slot1_v & pred_tk[1];

  // Fall-through is the following block
  assign seq_npc = (pc_q & BLK_MASK) + bpu_pkg::addr_t'(bpu_pkg::FETCH_BYTES);

  // First taken slot wins
  always_comb begin
    if (tk0) begin
      pred_npc = {lkp.target[0], 2'b00};
    end else if (tk1) begin
      pred_npc = {lkp.target[1], 2'b00};
    end else begin
      pred_npc = seq_npc;
    end
  end

  // ==================================================
  // PC register and handshake
  // ==================================================

  // Low for one cycle after reset while the tables load
  assign fetch_valid_o = primed_q;
  assign fire          = fetch_valid_o & fetch_ready_i;

  // Redirect first, then accepted prediction, else hold
  always_comb begin
    if (redirect_i) begin
      npc = redirect_target_i;
    end else if (fire) begin
      npc = pred_npc;
    end else begin
      npc = pc_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q     <= RESET_PC;
      primed_q <= 1'b0;
    end else begin
      pc_q     <= npc;
      primed_q <= 1'b1;
    end
  end

  // Tables read at the next pc so results line up with pc_q
  assign lkp.rd_pc = npc;
  assign rd_pc_o   = npc;

  // Response
  assign fetch_pc_o   = pc_q;
  assign fetch_npc_o  = pred_npc;
  assign slot_valid_o = {slot1_v, slot0_v};
  assign taken_o      = tk0 | tk1;
  // Slot 1 only when it is the taken one
  assign br_slot_o    = tk1;

endmodule

`default_nettype wire

// File: hw/pattern_history_table.sv
// Two-bank table of 2-bit saturating direction counters with synchronous read
`default_nettype none

module pattern_history_table #(
  parameter int unsigned PHT_IDX_W = 5
) (
  input  logic                 clk,
  input  logic                 rst_n,
  bpu_upd_if.pht_snk           upd,
  input  bpu_pkg::addr_t       rd_pc_i,
  output bpu_pkg::slot_mask_t  pred_taken_o
);

  // Counters per bank
  localparam int unsigned DEPTH = 1 << PHT_IDX_W;

  // ==================================================
  // Counter training
  // ==================================================

  bpu_pkg::ctr_t         ctr [2][DEPTH];

  logic                  train;
  logic                  wr_bank;
  logic [PHT_IDX_W-1:0]  wr_idx;
  logic [PHT_IDX_W-1:0]  rd_idx;
  bpu_pkg::ctr_t         cur_ctr;
  bpu_pkg::ctr_t         nxt_ctr;

  // Only conditional branches train
  assign train   = upd.valid && (upd.br_type == bpu_pkg::BR_COND);
  assign wr_bank = upd.pc[2];
  assign wr_idx  = upd.pc[PHT_IDX_W+2:3];
  assign rd_idx  = rd_pc_i[PHT_IDX_W+2:3];
  assign cur_ctr = ctr[wr_bank][wr_idx];

  // Saturate at 00 and 11
  always_comb begin
    nxt_ctr = cur_ctr;
    if (upd.taken) begin
      if (cur_ctr != 2'b11) begin
        nxt_ctr = bpu_pkg::ctr_t'(cur_ctr + 2'd1);
      end
    end else if (cur_ctr != 2'b00) begin
      nxt_ctr = bpu_pkg::ctr_t'(cur_ctr - 2'd1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int b = 0; b < 2; b++) begin
        for (int i = 0; i < DEPTH; i++) begin
          ctr[b][i] <= bpu_pkg::CTR_RESET;
        end
      end
    end else if (train) begin
      ctr[wr_bank][wr_idx] <= nxt_ctr;
    end
  end

  // ==================================================
  // Synchronous read
  // ==================================================

  bpu_pkg::slot_mask_t  pred_q;

  // Counter msb only, read before a same-cycle train
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pred_q <= '0;
    end else begin
      pred_q[0] <= ctr[0][rd_idx][1];
      pred_q[1] <= ctr[1][rd_idx][1];
    end
  end

  assign pred_taken_o = pred_q;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_bpu -f files.f
out=$(./obj_dir/Vtb_bpu 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'Simulation passed'; then
  exit 0
fi
exit 1

// File: testbench/bpu_props.sv
// Concurrent checks on the fetch handshake and reset priming of the next-PC logic
`default_nettype none

module bpu_props (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_valid_i,
  input  logic                 fetch_ready_i,
  input  logic                 redirect_i,
  input  bpu_pkg::addr_t       fetch_pc_i,
  input  bpu_pkg::slot_mask_t  slot_valid_i
);

  // ==================================================
  // Handshake rules
  // ==================================================

  // Tables still priming on the first edge out of reset
  a_prime_low: assert property (@(posedge clk) $rose(rst_n) |-> !fetch_valid_i)
    else $error("fetch_valid_o high in the priming cycle");

  // Stalled fetch keeps its pc
  a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid_i && !fetch_ready_i && !redirect_i |=> $stable(fetch_pc_i))
    else $error("fetch pc moved under back-pressure");

  // Some slot always usable
  a_mask_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid_i |-> (slot_valid_i != 2'b00))
    else $error("slot_valid_o empty on a valid fetch");

endmodule

bind next_pc_logic bpu_props u_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .fetch_valid_i (fetch_valid_o),
  .fetch_ready_i (fetch_ready_i),
  .redirect_i    (redirect_i),
  .fetch_pc_i    (fetch_pc_o),
  .slot_valid_i  (slot_valid_o)
);

`default_nettype wire

// File: testbench/tb_bpu.sv
// Testbench for the two-wide fetch predictor, checked against a cycle model
`default_nettype none

module tb_bpu;

  localparam int unsigned    BTB_IDX_W = 4;
  localparam int unsigned    PHT_IDX_W = 5;
  localparam bpu_pkg::addr_t RESET_PC  = 32'h1c00_0000;
  localparam int unsigned    BTB_DEPTH = 1 << BTB_IDX_W;
  localparam int unsigned    PHT_DEPTH = 1 << PHT_IDX_W;
  localparam int unsigned    TAG_W     = 29 - BTB_IDX_W;
  // Keeps random addresses in 512 bytes so entries alias
  localparam logic [31:0]    WIN_MASK  = 32'h0000_01fc;

  logic                 clk;
  logic                 rst_n;
  logic                 upd_valid_i;
  bpu_pkg::addr_t       upd_pc_i;
  bpu_pkg::addr_t       upd_target_i;
  bpu_pkg::br_type_e    upd_br_type_i;
  logic                 upd_taken_i;
  logic                 redirect_i;
  bpu_pkg::addr_t       redirect_target_i;
  logic                 fetch_ready_i;
  logic                 fetch_valid_o;
  bpu_pkg::addr_t       fetch_pc_o;
  bpu_pkg::addr_t       fetch_npc_o;
  bpu_pkg::slot_mask_t  slot_valid_o;
  logic                 taken_o;
  logic                 br_slot_o;

  int           seed = 32'h489d_0209;
  int           n_checks;
  int           n_errors;
  int           n_timeouts;
  logic [31:0]  r;
  logic [31:0]  n_fire;

  bpu_top #(
    .BTB_IDX_W (BTB_IDX_W),
    .PHT_IDX_W (PHT_IDX_W),
    .RESET_PC  (RESET_PC)
  ) dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .upd_valid_i       (upd_valid_i),
    .upd_pc_i          (upd_pc_i),
    .upd_target_i      (upd_target_i),
    .upd_br_type_i     (upd_br_type_i),
    .upd_taken_i       (upd_taken_i),
    .redirect_i        (redirect_i),
    .redirect_target_i (redirect_target_i),
    .fetch_ready_i     (fetch_ready_i),
    .fetch_valid_o     (fetch_valid_o),
    .fetch_pc_o        (fetch_pc_o),
    .fetch_npc_o       (fetch_npc_o),
    .slot_valid_o      (slot_valid_o),
    .taken_o           (taken_o),
    .br_slot_o         (br_slot_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==================================================
  // Reference model
  // ==================================================

  // Table contents
  logic                 m_bv    [2][BTB_DEPTH];
  logic [TAG_W-1:0]     m_btag  [2][BTB_DEPTH];
  bpu_pkg::br_type_e    m_btype [2][BTB_DEPTH];
  bpu_pkg::word_addr_t  m_btgt  [2][BTB_DEPTH];
  bpu_pkg::ctr_t        m_pht   [2][PHT_DEPTH];
  // Lookup results for the current pc
  logic                 m_hit   [2];
  bpu_pkg::br_type_e    m_type  [2];
  bpu_pkg::word_addr_t  m_tgt   [2];
  logic                 m_pred  [2];
  bpu_pkg::addr_t       m_pc;
  logic                 m_primed;

  task automatic check_addr(input string name, input bpu_pkg::addr_t got,
                            input bpu_pkg::addr_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_mask(input string name, input bpu_pkg::slot_mask_t got,
                            input bpu_pkg::slot_mask_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Checks the response, then moves the model across the coming edge
  task automatic model_step();
    logic                  s0;
    logic                  s1;
    logic                  t0;
    logic                  t1;
    logic                  fire;
    logic                  bk;
    logic                  ptk [2];
    bpu_pkg::addr_t        exp_npc;
    bpu_pkg::addr_t        nxt_pc;
    logic [BTB_IDX_W-1:0]  bi;
    logic [PHT_IDX_W-1:0]  pi;
    bpu_pkg::ctr_t         c;
    for (int s = 0; s < 2; s++) begin
      ptk[s] = m_hit[s] && ((m_type[s] == bpu_pkg::BR_JUMP) ||
               ((m_type[s] == bpu_pkg::BR_COND) && m_pred[s]));
    end
    s0 = !m_pc[2];
    t0 = s0 && ptk[0];
    s1 = !t0;
    t1 = s1 && ptk[1];
    if (t0) begin
      exp_npc = {m_tgt[0], 2'b00};
    end else if (t1) begin
      exp_npc = {m_tgt[1], 2'b00};
    end else begin
      exp_npc = (m_pc & ~32'h7) + 32'd8;
    end
    check_bit("fetch_valid_o", fetch_valid_o, m_primed);
    if (m_primed) begin
      check_addr("fetch_pc_o", fetch_pc_o, m_pc);
      check_addr("fetch_npc_o", fetch_npc_o, exp_npc);
      check_mask("slot_valid_o", slot_valid_o, {s1, s0});
      check_bit("taken_o", taken_o, t0 | t1);
      check_bit("br_slot_o", br_slot_o, t1);
    end
    fire = m_primed && fetch_ready_i;
    nxt_pc = redirect_i ? redirect_target_i : (fire ? exp_npc : m_pc);
    // Read at the next pc sees the tables before this edge's write
    bi = nxt_pc[BTB_IDX_W+2:3];
    pi = nxt_pc[PHT_IDX_W+2:3];
    for (int b = 0; b < 2; b++) begin
      m_hit[b]  = m_bv[b][bi] && (m_btag[b][bi] == nxt_pc[31:BTB_IDX_W+3]);
      m_type[b] = m_btype[b][bi];
      m_tgt[b]  = m_btgt[b][bi];
      m_pred[b] = m_pht[b][pi][1];
    end
    if (upd_valid_i) begin
      bk = upd_pc_i[2];
      bi = upd_pc_i[BTB_IDX_W+2:3];
      pi = upd_pc_i[PHT_IDX_W+2:3];
      m_bv[bk][bi]    = (upd_br_type_i != bpu_pkg::BR_NONE);
      m_btag[bk][bi]  = upd_pc_i[31:BTB_IDX_W+3];
      m_btype[bk][bi] = upd_br_type_i;
      m_btgt[bk][bi]  = upd_target_i[31:2];
      // Counters train on conditional branches only
      if (upd_br_type_i == bpu_pkg::BR_COND) begin
        c = m_pht[bk][pi];
        if (upd_taken_i) begin
          if (c != 2'b11) begin
            c = c + 2'b01;
          end
        end else if (c != 2'b00) begin
          c = c - 2'b01;
        end
        m_pht[bk][pi] = c;
      end
    end
    m_pc     = nxt_pc;
    m_primed = 1'b1;
  endtask

  // ==================================================
  // Stimulus helpers
  // ==================================================

  // Returns just after the rising edge, where inputs get driven
  task automatic advance_cycle();
    @(negedge clk);
    model_step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_valid(input int limit);
    int n;
    n = 0;
    while (!fetch_valid_o && n < limit) begin
      advance_cycle();
      n++;
    end
    if (!fetch_valid_o) begin
      n_timeouts++;
      $display("timeout at %0t: fetch_valid_o still low after %0d cycles", $time, limit);
    end
  endtask

  task automatic send_update(input bpu_pkg::addr_t pc, input bpu_pkg::addr_t tgt,
                             input bpu_pkg::br_type_e kind, input logic tk);
    upd_valid_i   = 1'b1;
    upd_pc_i      = pc;
    upd_target_i  = tgt;
    upd_br_type_i = kind;
    upd_taken_i   = tk;
    advance_cycle();
    upd_valid_i   = 1'b0;
  endtask

  // Fetch must sit at the target one cycle later
  task automatic send_redirect(input bpu_pkg::addr_t tgt);
    redirect_i        = 1'b1;
    redirect_target_i = tgt;
    advance_cycle();
    redirect_i        = 1'b0;
    check_bit("fetch_valid_o", fetch_valid_o, 1'b1);
    check_addr("fetch_pc_o", fetch_pc_o, tgt);
  endtask

  task automatic run_random(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      r = $random(seed);
      upd_valid_i       = (r[1:0] == 2'b00);
      upd_taken_i       = r[4];
      redirect_i        = (r[9:5] == 5'd0);
      fetch_ready_i     = (r[11:10] != 2'b00);
      case (r[3:2])
        2'd0:    upd_br_type_i = bpu_pkg::BR_NONE;
        2'd3:    upd_br_type_i = bpu_pkg::BR_JUMP;
        default: upd_br_type_i = bpu_pkg::BR_COND;
      endcase
      r = $random(seed);
      upd_pc_i          = RESET_PC | (r & WIN_MASK);
      r = $random(seed);
      upd_target_i      = RESET_PC | (r & WIN_MASK);
      r = $random(seed);
      redirect_target_i = RESET_PC | (r & WIN_MASK);
      advance_cycle();
    end
  endtask

  // ==================================================
  // Test sequence
  // ==================================================

  initial begin
    n_checks = 0;
    n_errors = 0;
    n_timeouts = 0;
    rst_n = 1'b0;
    upd_valid_i = 1'b0;
    upd_pc_i = '0;
    upd_target_i = '0;
    upd_br_type_i = bpu_pkg::BR_NONE;
    upd_taken_i = 1'b0;
    redirect_i = 1'b0;
    redirect_target_i = '0;
    fetch_ready_i = 1'b0;
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < BTB_DEPTH; i++) begin
        m_bv[b][i] = 1'b0;
        m_btag[b][i] = '0;
        m_btype[b][i] = bpu_pkg::BR_NONE;
        m_btgt[b][i] = '0;
      end
      for (int i = 0; i < PHT_DEPTH; i++) begin
        m_pht[b][i] = bpu_pkg::CTR_RESET;
      end
      m_hit[b] = 1'b0;
      m_type[b] = bpu_pkg::BR_NONE;
      m_tgt[b] = '0;
      m_pred[b] = 1'b0;
    end
    m_pc = RESET_PC;
    m_primed = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // First fetch after priming
    wait_valid(4);
    check_addr("fetch_pc_o", fetch_pc_o, RESET_PC);
    check_mask("slot_valid_o", slot_valid_o, 2'b11);
    check_addr("fetch_npc_o", fetch_npc_o, RESET_PC + 32'd8);

    // Sequential fetch with an empty BTB under random ready
    // Valid stays high once primed, so every ready cycle is a handshake
    n_fire = '0;
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      fetch_ready_i = r[0] | r[1];
      if (fetch_ready_i) begin
        n_fire = n_fire + 32'd1;
      end
      advance_cycle();
    end
    check_addr("fetch_pc_o", fetch_pc_o, RESET_PC + (n_fire << 3));
    fetch_ready_i = 1'b0;

    // Jump in slot 0 shadows slot 1
    send_update(32'h1c00_0100, 32'h1c00_0040, bpu_pkg::BR_JUMP, 1'b1);
    send_redirect(32'h1c00_0100);
    check_bit("taken_o", taken_o, 1'b1);
    check_bit("br_slot_o", br_slot_o, 1'b0);
    check_mask("slot_valid_o", slot_valid_o, 2'b01);
    check_addr("fetch_npc_o", fetch_npc_o, 32'h1c00_0040);

    // Jump in slot 1
    send_update(32'h1c00_018c, 32'h1c00_0060, bpu_pkg::BR_JUMP, 1'b1);
    send_redirect(32'h1c00_0188);
    check_bit("taken_o", taken_o, 1'b1);
    check_bit("br_slot_o", br_slot_o, 1'b1);
    check_mask("slot_valid_o", slot_valid_o, 2'b11);
    check_addr("fetch_npc_o", fetch_npc_o, 32'h1c00_0060);

    // Conditional branch trained up, then back down
    send_update(32'h1c00_0110, 32'h1c00_0020, bpu_pkg::BR_COND, 1'b1);
    send_update(32'h1c00_0110, 32'h1c00_0020, bpu_pkg::BR_COND, 1'b1);
    send_redirect(32'h1c00_0110);
    check_bit("taken_o", taken_o, 1'b1);
    check_addr("fetch_npc_o", fetch_npc_o, 32'h1c00_0020);
    send_update(32'h1c00_0110, 32'h1c00_0020, bpu_pkg::BR_COND, 1'b0);
    send_update(32'h1c00_0110, 32'h1c00_0020, bpu_pkg::BR_COND, 1'b0);
    send_redirect(32'h1c00_0110);
    check_bit("taken_o", taken_o, 1'b0);
    check_addr("fetch_npc_o", fetch_npc_o, 32'h1c00_0118);

    // Odd-word target skips slot 0
    send_redirect(32'h1c00_0124);
    check_mask("slot_valid_o", slot_valid_o, 2'b10);

    run_random(2000);
    upd_valid_i = 1'b0;
    redirect_i = 1'b0;
    advance_cycle();

    $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
